/* sim.f */
+incdir+rtl
rtl/gpu_mem_pkg.sv
rtl/mem_issue_if.sv
rtl/mem_line_if.sv
rtl/mem_addr_gen.sv
rtl/mem_cfg_regs.sv
rtl/mem_coalescer.sv
rtl/mem_line_ram.sv
rtl/mem_writeback.sv
rtl/gpu_mem_stage.sv
tb/tb_gpu_mem_stage.sv

/* tb/tb_gpu_mem_stage.sv */
`include "gpu_mem_defs.svh"

module tb_gpu_mem_stage;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BUS_W = `NUM_LANES * `WORD_W;
	localparam int RESET_CYC = 10;
	localparam int RAND_REQ = 20;
	// Fill, random, write/read, shared limit, back-to-back and counter requests.
	localparam int NUM_REQ = 64 + RAND_REQ + 2 + 2 + 3 + 2;
	localparam int TIMEOUT_CYC = 40 * NUM_REQ + RESET_CYC;

	typedef struct packed {
		logic [9:0]       tag;
		logic [7:0]       mask;
		logic [7:0]       fault;
		logic [BUS_W-1:0] data;
		logic             chk;
		logic [31:0]      due;
	} done_rec_t;

	logic             clk;
	logic             rst_n_i;
	logic             req_valid_i;
	logic             mem_read_i;
	logic             mem_write_i;
	logic             shared_global_bar_i;
	logic [2:0]       warp_id_i;
	logic [1:0]       scb_id_i;
	logic [4:0]       reg_addr_i;
	logic [7:0]       pam_i;
	logic [BUS_W-1:0] rs_data_i;
	logic [15:0]      offset_i;
	logic [BUS_W-1:0] write_data_i;
	logic             busy_o;
	logic             cfg_we_i;
	logic [1:0]       cfg_addr_i;
	logic [15:0]      cfg_wdata_i;
	logic [15:0]      cfg_rdata_o;
	logic             done_o;
	logic [2:0]       done_warp_id_o;
	logic [1:0]       done_scb_id_o;
	logic [4:0]       done_reg_addr_o;
	logic [7:0]       done_mask_o;
	logic [BUS_W-1:0] rd_data_o;
	logic [7:0]       fault_lanes_o;

	// Reference model of the line RAM, the config registers and the pending warps.
	logic [31:0]      mem_m [64][8];
	int               limit_m;
	logic             fault_m;
	logic [15:0]      count_m;
	done_rec_t        exp_q [$];
	done_rec_t        head = '0;
	int               exp_cnt = 0;
	int               cycle_cnt = 0;
	int               errors = 0;
	logic             cfg_chk;
	logic [15:0]      cfg_exp;
	string            test_name = "reset";

	gpu_mem_stage u_gpu_mem_stage (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] fill_word(input int row, input int w);
		return {10'h2a5, row[5:0], w[2:0], ~row[5:0], ~w[2:0], 4'hc};
	endfunction

	// Applies one captured request to the model and returns its expected done record.
	task automatic model_request(input logic is_wr, input logic is_sh, input logic [9:0] tag,
		input logic [7:0] pam, input logic [BUS_W-1:0] rs, input logic [15:0] ofs,
		input logic [BUS_W-1:0] wd, output done_rec_t rec, output int n);
		logic [31:0] ea;
		logic [5:0]  row [8];
		logic [2:0]  word [8];
		logic [31:0] lines_hit;
		rec = '0;
		rec.tag = tag;
		lines_hit = '0;
		for (int l = 0; l < 8; l++)
		begin
			ea = rs[l*32 +: 32] + {{16{ofs[15]}}, ofs};
			row[l] = {is_sh, ea[9:5]};
			word[l] = ea[4:2];
			if (pam[l] && is_sh && int'(ea[9:5]) >= limit_m)
				rec.fault[l] = 1'b1;
			else if (pam[l])
			begin
				rec.mask[l] = 1'b1;
				lines_hit[ea[9:5]] = 1'b1;
			end
		end
		n = $countones(lines_hit);
		// Ascending lane order lets the highest lane win a shared word.
		for (int l = 0; l < 8; l++)
		begin
			if (rec.mask[l] && is_wr)
				mem_m[row[l]][word[l]] = wd[l*32 +: 32];
			else if (rec.mask[l])
				rec.data[l*32 +: 32] = mem_m[row[l]][word[l]];
		end
	endtask

	always @(posedge clk)
	begin
		done_rec_t rec;
		int        n;
		cycle_cnt <= cycle_cnt + 1;
		if (!rst_n_i)
		begin
			exp_q.delete();
			limit_m = 32;
			fault_m = 1'b0;
			count_m = '0;
		end
		else
		begin
			if (done_o && exp_q.size() > 0)
				void'(exp_q.pop_front());
			if (cfg_we_i && cfg_addr_i == 2'd0)
				limit_m = (cfg_wdata_i > 16'd32) ? 32 : int'(cfg_wdata_i);
			if (cfg_we_i && cfg_addr_i == 2'd1)
				fault_m = 1'b0;
			if (req_valid_i && !busy_o && (mem_read_i || mem_write_i))
			begin
				model_request(mem_write_i, shared_global_bar_i,
					{warp_id_i, scb_id_i, reg_addr_i}, pam_i, rs_data_i, offset_i,
					write_data_i, rec, n);
				// Latency is only fixed when nothing else is in flight.
				rec.chk = (exp_q.size() == 0);
				rec.due = 32'(cycle_cnt + n + 2);
				count_m = count_m + 16'(n);
				if (rec.fault != '0)
					fault_m = 1'b1;
				exp_q.push_back(rec);
			end
		end
		exp_cnt <= exp_q.size();
		head <= (exp_q.size() > 0) ? exp_q[0] : '0;
	end

	chk_reset_idle: assert property (@(posedge clk) $rose(rst_n_i) |-> !busy_o && !done_o)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %s: busy_o or done_o is high right after reset", test_name);
		end

	chk_stray_done: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o |-> exp_cnt > 0)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %s: done_o pulsed with no request outstanding", test_name);
		end

	chk_done_tag: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o && exp_cnt > 0 |-> {done_warp_id_o, done_scb_id_o, done_reg_addr_o} == head.tag)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %s: tag expected %h actual %h", test_name, $sampled(head.tag),
				$sampled({done_warp_id_o, done_scb_id_o, done_reg_addr_o}));
		end

	chk_done_mask: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o && exp_cnt > 0 |-> done_mask_o == head.mask)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %s: done_mask expected %h actual %h", test_name,
				$sampled(head.mask), $sampled(done_mask_o));
		end

	chk_fault_lanes: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o && exp_cnt > 0 |-> fault_lanes_o == head.fault)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %s: fault_lanes expected %h actual %h", test_name,
				$sampled(head.fault), $sampled(fault_lanes_o));
		end

	chk_rd_data: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o && exp_cnt > 0 |-> rd_data_o == head.data)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %s: rd_data expected %h actual %h", test_name,
				$sampled(head.data), $sampled(rd_data_o));
		end

	chk_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o && exp_cnt > 0 && head.chk |-> cycle_cnt == head.due)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %s: done cycle expected %0d actual %0d", test_name,
				$sampled(head.due), $sampled(cycle_cnt));
		end

	chk_cfg_read: assert property (@(posedge clk) disable iff (!rst_n_i)
		cfg_chk |-> cfg_rdata_o == cfg_exp)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %s: cfg register %0d expected %h actual %h", test_name,
				$sampled(cfg_addr_i), $sampled(cfg_exp), $sampled(cfg_rdata_o));
		end

	// Tasks below are entered and left on a falling edge.
	task automatic drive_req(input logic rd, input logic wr, input logic sh,
		input logic [9:0] tag, input logic [7:0] pam, input logic [BUS_W-1:0] rs,
		input logic [15:0] ofs, input logic [BUS_W-1:0] wd);
		mem_read_i = rd;
		mem_write_i = wr;
		shared_global_bar_i = sh;
		{warp_id_i, scb_id_i, reg_addr_i} = tag;
		pam_i = pam;
		rs_data_i = rs;
		offset_i = ofs;
		write_data_i = wd;
		req_valid_i = 1'b1;
	endtask

	task automatic send_req(input logic rd, input logic wr, input logic sh,
		input logic [9:0] tag, input logic [7:0] pam, input logic [BUS_W-1:0] rs,
		input logic [15:0] ofs, input logic [BUS_W-1:0] wd);
		while (busy_o)
			@(negedge clk);
		drive_req(rd, wr, sh, tag, pam, rs, ofs, wd);
		@(negedge clk);
		req_valid_i = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_cnt != 0)
			@(negedge clk);
	endtask

	task automatic cfg_write(input logic [1:0] addr, input logic [15:0] data);
		cfg_we_i = 1'b1;
		cfg_addr_i = addr;
		cfg_wdata_i = data;
		@(negedge clk);
		cfg_we_i = 1'b0;
	endtask

	task automatic cfg_read(input logic [1:0] addr, input logic [15:0] expected);
		cfg_addr_i = addr;
		cfg_exp = expected;
		cfg_chk = 1'b1;
		@(negedge clk);
		cfg_chk = 1'b0;
	endtask

	initial
	begin
		wait (cycle_cnt >= TIMEOUT_CYC);
		$display("Timeout after %0d cycles with %0d requests still outstanding",
			cycle_cnt, exp_cnt);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		logic [BUS_W-1:0] rs;
		logic [BUS_W-1:0] wd;
		logic [31:0]      base;
		int               op;
		int               shr_line [8];
		void'($urandom(32'h9389_9ef1));
		rst_n_i = 1'b0;
		req_valid_i = 1'b0;
		mem_read_i = 1'b0;
		mem_write_i = 1'b0;
		shared_global_bar_i = 1'b0;
		{warp_id_i, scb_id_i, reg_addr_i} = '0;
		pam_i = '0;
		rs_data_i = '0;
		offset_i = '0;
		write_data_i = '0;
		cfg_we_i = 1'b0;
		cfg_addr_i = '0;
		cfg_wdata_i = '0;
		cfg_chk = 1'b0;
		cfg_exp = '0;
		repeat (RESET_CYC) @(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);

		test_name = "fill";
		cfg_read(2'd0, 16'd32);
		cfg_read(2'd2, 16'd0);
		for (int row = 0; row < 64; row++)
		begin
			for (int l = 0; l < 8; l++)
			begin
				rs[l*32 +: 32] = 32'((row % 32) * 32 + l * 4);
				wd[l*32 +: 32] = fill_word(row, l);
			end
			send_req(1'b0, 1'b1, row >= 32, 10'(row), 8'hff, rs, 16'h0, wd);
			wait_idle();
		end

		test_name = "random";
		for (int i = 0; i < RAND_REQ; i++)
		begin
			base = $urandom;
			for (int l = 0; l < 8; l++)
			begin
				rs[l*32 +: 32] = base + $urandom_range(96, 0);
				wd[l*32 +: 32] = $urandom;
			end
			// 0 reads, 1 writes, 2 sets both strobes.
			op = $urandom_range(2, 0);
			send_req(op != 1, op != 0, 1'($urandom_range(1, 0)), 10'($urandom_range(1023, 0)),
				8'($urandom_range(255, 0)), rs, 16'($urandom_range(65535, 0)), wd);
			wait_idle();
		end

		test_name = "write_read";
		for (int l = 0; l < 8; l++)
		begin
			rs[l*32 +: 32] = 32'(3 * 32 + (l % 4) * 4);
			wd[l*32 +: 32] = $urandom;
		end
		send_req(1'b0, 1'b1, 1'b0, 10'h155, 8'hff, rs, 16'h0, wd);
		wait_idle();
		for (int l = 0; l < 8; l++)
			rs[l*32 +: 32] = 32'(3 * 32 + l * 4 + 16);
		send_req(1'b1, 1'b0, 1'b0, 10'h2aa, 8'h5a, rs, 16'hfff0, wd);
		wait_idle();

		test_name = "shared_limit";
		cfg_write(2'd0, 16'd8);
		cfg_read(2'd0, 16'(limit_m));
		shr_line = '{20, 3, 9, 3, 31, 7, 8, 0};
		for (int l = 0; l < 8; l++)
			rs[l*32 +: 32] = 32'h4000_0000 + 32'(shr_line[l] * 32 + l * 4);
		send_req(1'b1, 1'b0, 1'b1, 10'h0c3, 8'hff, rs, 16'h0, wd);
		wait_idle();
		for (int l = 0; l < 8; l++)
			rs[l*32 +: 32] = 32'((8 + l * 3) * 32 + l * 4);
		send_req(1'b1, 1'b0, 1'b1, 10'h0e7, 8'hff, rs, 16'h0, wd);
		wait_idle();
		cfg_read(2'd1, {15'd0, fault_m});
		cfg_write(2'd1, 16'h0);
		cfg_read(2'd1, {15'd0, fault_m});
		cfg_write(2'd0, 16'd100);
		cfg_read(2'd0, 16'(limit_m));

		test_name = "back_to_back";
		for (int l = 0; l < 8; l++)
			rs[l*32 +: 32] = 32'(l * 32 + l * 4);
		send_req(1'b1, 1'b0, 1'b0, 10'h101, 8'hff, rs, 16'h0, wd);
		for (int l = 0; l < 8; l++)
			rs[l*32 +: 32] = 32'(5 * 32 + l * 4);
		send_req(1'b1, 1'b0, 1'b1, 10'h202, 8'h0f, rs, 16'h0, wd);
		// The second warp still waits, so this strobe meets busy_o high.
		drive_req(1'b1, 1'b0, 1'b0, 10'h3ff, 8'hff, rs, 16'h0, wd);
		@(negedge clk);
		req_valid_i = 1'b0;
		wait_idle();

		test_name = "counter";
		send_req(1'b0, 1'b0, 1'b0, 10'h011, 8'hff, rs, 16'h0, wd);
		repeat (10) @(negedge clk);
		send_req(1'b1, 1'b0, 1'b0, 10'h022, 8'h00, rs, 16'h0, wd);
		wait_idle();
		cfg_read(2'd2, count_m);

		repeat (2) @(negedge clk);
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* rtl/gpu_mem_stage.sv */
`include "gpu_mem_defs.svh"

module gpu_mem_stage (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic                           req_valid_i,
	input  logic                           mem_read_i,
	input  logic                           mem_write_i,
	input  logic                           shared_global_bar_i,
	input  logic [2:0]                     warp_id_i,
	input  logic [1:0]                     scb_id_i,
	input  logic [4:0]                     reg_addr_i,
	input  logic [`NUM_LANES-1:0]          pam_i,
	input  logic [`NUM_LANES*`WORD_W-1:0]  rs_data_i,
	input  logic [15:0]                    offset_i,
	input  logic [`NUM_LANES*`WORD_W-1:0]  write_data_i,
	output logic                           busy_o,
	input  logic                           cfg_we_i,
	input  logic [1:0]                     cfg_addr_i,
	input  logic [15:0]                    cfg_wdata_i,
	output logic [15:0]                    cfg_rdata_o,
	output logic                           done_o,
	output logic [2:0]                     done_warp_id_o,
	output logic [1:0]                     done_scb_id_o,
	output logic [4:0]                     done_reg_addr_o,
	output logic [`NUM_LANES-1:0]          done_mask_o,
	output logic [`NUM_LANES*`WORD_W-1:0]  rd_data_o,
	output logic [`NUM_LANES-1:0]          fault_lanes_o
);

	gpu_mem_pkg::lane_words_t rs_words;
	gpu_mem_pkg::lane_words_t wr_words;
	gpu_mem_pkg::lane_words_t rd_words;
	gpu_mem_pkg::warp_tag_t   req_tag;
	gpu_mem_pkg::warp_tag_t   co_tag;
	gpu_mem_pkg::warp_tag_t   done_tag;
	gpu_mem_pkg::lane_mask_t  co_drop;
	logic [`LINE_IDX_W:0]     shared_limit;
	logic                     co_first;
	logic                     co_last;
	logic                     fault_pulse;
	logic                     access_pulse;

	mem_issue_if issue_bus ();
	mem_line_if  line_bus ();

	always_comb
	begin
		for (int l = 0; l < `NUM_LANES; l++)
		begin
			rs_words[l] = rs_data_i[l*`WORD_W +: `WORD_W];
			wr_words[l] = write_data_i[l*`WORD_W +: `WORD_W];
			rd_data_o[l*`WORD_W +: `WORD_W] = rd_words[l];
		end
	end

	assign req_tag = '{warp_id: warp_id_i, scb_id: scb_id_i, reg_addr: reg_addr_i};
	assign done_warp_id_o  = done_tag.warp_id;
	assign done_scb_id_o   = done_tag.scb_id;
	assign done_reg_addr_o = done_tag.reg_addr;

	mem_addr_gen u_mem_addr_gen (
		.clk                 (clk),
		.rst_n_i             (rst_n_i),
		.req_valid_i         (req_valid_i),
		.mem_read_i          (mem_read_i),
		.mem_write_i         (mem_write_i),
		.shared_global_bar_i (shared_global_bar_i),
		.tag_i               (req_tag),
		.pam_i               (pam_i),
		.rs_data_i           (rs_words),
		.offset_i            (offset_i),
		.write_data_i        (wr_words),
		.busy_o              (busy_o),
		.iss                 (issue_bus.src)
	);

	mem_cfg_regs u_mem_cfg_regs (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.cfg_we_i       (cfg_we_i),
		.cfg_addr_i     (cfg_addr_i),
		.cfg_wdata_i    (cfg_wdata_i),
		.cfg_rdata_o    (cfg_rdata_o),
		.fault_pulse_i  (fault_pulse),
		.access_pulse_i (access_pulse),
		.shared_limit_o (shared_limit)
	);

	mem_coalescer u_mem_coalescer (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.iss            (issue_bus.dst),
		.acc            (line_bus.ctl),
		.shared_limit_i (shared_limit),
		.fault_pulse_o  (fault_pulse),
		.access_pulse_o (access_pulse),
		.acc_first_o    (co_first),
		.acc_last_o     (co_last),
		.drop_mask_o    (co_drop),
		.tag_o          (co_tag)
	);

	mem_line_ram u_mem_line_ram (
		.clk (clk),
		.acc (line_bus.mem)
	);

	mem_writeback u_mem_writeback (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.mon           (line_bus.mon),
		.acc_first_i   (co_first),
		.acc_last_i    (co_last),
		.lane_mask_i   (line_bus.lane_mask),
		.drop_mask_i   (co_drop),
		.tag_i         (co_tag),
		.is_write_i    (line_bus.acc_write),
		.done_o        (done_o),
		.done_tag_o    (done_tag),
		.done_mask_o   (done_mask_o),
		.rd_data_o     (rd_words),
		.fault_lanes_o (fault_lanes_o)
	);

endmodule

/* rtl/mem_writeback.sv */
`include "gpu_mem_defs.svh"

module mem_writeback (
	input  logic                     clk,
	input  logic                     rst_n_i,
	mem_line_if.mon                  mon,
	input  logic                     acc_first_i,
	input  logic                     acc_last_i,
	input  gpu_mem_pkg::lane_mask_t  lane_mask_i,
	input  gpu_mem_pkg::lane_mask_t  drop_mask_i,
	input  gpu_mem_pkg::warp_tag_t   tag_i,
	input  logic                     is_write_i,
	output logic                     done_o,
	output gpu_mem_pkg::warp_tag_t   done_tag_o,
	output gpu_mem_pkg::lane_mask_t  done_mask_o,
	output gpu_mem_pkg::lane_words_t rd_data_o,
	output gpu_mem_pkg::lane_mask_t  fault_lanes_o
);

	gpu_mem_pkg::lane_mask_t  mask_q;
	gpu_mem_pkg::lane_mask_t  served_q;
	gpu_mem_pkg::lane_words_t res_q;
	logic                     first_q;
	logic                     write_q;

	// The access mask is delayed so that it lines up with the RAM read data.
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			done_o   <= 1'b0;
			first_q  <= 1'b0;
			mask_q   <= '0;
			served_q <= '0;
		end
		else
		begin
			done_o   <= acc_last_i;
			first_q  <= acc_first_i;
			mask_q   <= lane_mask_i;
			served_q <= done_mask_o;
		end
	end

	always_ff @(posedge clk)
	begin
		write_q <= is_write_i;
		res_q   <= rd_data_o;
		if (acc_first_i)
		begin
			done_tag_o    <= tag_i;
			fault_lanes_o <= drop_mask_i;
		end
	end

	always_comb
	begin
		done_mask_o = (first_q ? '0 : served_q) | mask_q;
		for (int l = 0; l < `NUM_LANES; l++)
		begin
			if (mask_q[l] && !write_q)
				rd_data_o[l] = mon.rdata[l];
			else if (first_q)
				rd_data_o[l] = '0;
			else
				rd_data_o[l] = res_q[l];
		end
	end

endmodule

/* rtl/mem_line_ram.sv */
`include "gpu_mem_defs.svh"

module mem_line_ram (
	input  logic    clk,
	mem_line_if.mem acc
);

	// Global lines sit in the lower half and shared lines in the upper half.
	gpu_mem_pkg::lane_words_t mem_q [2*`SPACE_LINES];
	gpu_mem_pkg::lane_words_t line_q;
	logic [`WORD_SEL_W-1:0]   sel_q [`NUM_LANES];
	logic [`LINE_IDX_W:0]     row;

	assign row = {acc.acc_line.space, acc.acc_line.idx};

	always_ff @(posedge clk)
	begin
		if (acc.acc_valid)
		begin
			if (acc.acc_write)
			begin
				// Later lanes overwrite earlier ones on a shared word.
				for (int l = 0; l < `NUM_LANES; l++)
				begin
					if (acc.lane_mask[l])
						mem_q[row][acc.word_sel[l]] <= acc.wdata[l];
				end
			end
			else
			begin
				line_q <= mem_q[row];
				sel_q  <= acc.word_sel;
			end
		end
	end

	always_comb
	begin
		for (int l = 0; l < `NUM_LANES; l++)
			acc.rdata[l] = line_q[sel_q[l]];
	end

endmodule

/* rtl/mem_coalescer.sv */
`include "gpu_mem_defs.svh"

module mem_coalescer (
	input  logic                    clk,
	input  logic                    rst_n_i,
	mem_issue_if.dst                iss,
	mem_line_if.ctl                 acc,
	input  logic [`LINE_IDX_W:0]    shared_limit_i,
	output logic                    fault_pulse_o,
	output logic                    access_pulse_o,
	output logic                    acc_first_o,
	output logic                    acc_last_o,
	output gpu_mem_pkg::lane_mask_t drop_mask_o,
	output gpu_mem_pkg::warp_tag_t  tag_o
);

	gpu_mem_pkg::lane_mask_t  pend_q;
	gpu_mem_pkg::lane_mask_t  drop_q;
	gpu_mem_pkg::lane_mask_t  drop_now;
	gpu_mem_pkg::lane_mask_t  kept;
	gpu_mem_pkg::lane_mask_t  src_mask;
	gpu_mem_pkg::lane_mask_t  group;
	gpu_mem_pkg::lane_mask_t  pend_next;
	gpu_mem_pkg::lane_words_t wdata_q;
	gpu_mem_pkg::warp_tag_t   tag_q;
	logic [`LINE_IDX_W-1:0]   line_q [`NUM_LANES];
	logic [`LINE_IDX_W-1:0]   src_line [`NUM_LANES];
	logic [`WORD_SEL_W-1:0]   wsel_q [`NUM_LANES];
	logic [`WORD_SEL_W-1:0]   src_wsel [`NUM_LANES];
	logic [`LINE_IDX_W-1:0]   sel_line;
	logic                     write_q;
	logic                     shared_q;
	logic                     first_q;
	logic                     last_q;
	logic                     take;
	logic                     issue;
	logic                     marker;
	logic                     lead_drop;

	// The coalescer is free once its last registered access has gone out.
	assign take = iss.valid && !acc.acc_valid;
	assign iss.take = take;

	always_comb
	begin
		for (int l = 0; l < `NUM_LANES; l++)
		begin
			drop_now[l] = iss.pam[l] && iss.is_shared &&
				({1'b0, iss.eff_addr[l][`LINE_OFS +: `LINE_IDX_W]} >= shared_limit_i);
			src_line[l] = take ? iss.eff_addr[l][`LINE_OFS +: `LINE_IDX_W] : line_q[l];
			src_wsel[l] = take ? iss.eff_addr[l][2 +: `WORD_SEL_W] : wsel_q[l];
		end
		kept = iss.pam & ~drop_now;
		src_mask = take ? kept : pend_q;
		lead_drop = iss.is_shared &&
			({1'b0, iss.leader_line[`LINE_IDX_W-1:0]} >= shared_limit_i);
		sel_line = iss.leader_line[`LINE_IDX_W-1:0];
		if (!take || lead_drop)
		begin
			for (int l = `NUM_LANES-1; l >= 0; l--)
			begin
				if (src_mask[l])
					sel_line = src_line[l];
			end
		end
		for (int l = 0; l < `NUM_LANES; l++)
			group[l] = src_mask[l] && (src_line[l] == sel_line);
		pend_next = src_mask & ~group;
	end

	assign issue = (src_mask != '0);

	// Everything was dropped or masked off, so only a marker goes to writeback.
	assign marker = take && (kept == '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			acc.acc_valid <= 1'b0;
			acc.lane_mask <= '0;
			pend_q        <= '0;
			first_q       <= 1'b0;
			last_q        <= 1'b0;
		end
		else
		begin
			acc.acc_valid <= issue;
			acc.lane_mask <= group;
			pend_q        <= pend_next;
			first_q       <= take && issue;
			last_q        <= issue && (pend_next == '0);
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			line_q   <= src_line;
			wsel_q   <= src_wsel;
			wdata_q  <= iss.wdata;
			write_q  <= iss.is_write;
			shared_q <= iss.is_shared;
			tag_q    <= iss.tag;
			drop_q   <= drop_now;
		end
		if (issue)
		begin
			acc.word_sel <= src_wsel;
			if (take)
			begin
				acc.acc_write <= iss.is_write;
				acc.acc_line  <= '{space: iss.is_shared, idx: sel_line};
				acc.wdata     <= iss.wdata;
			end
			else
			begin
				acc.acc_write <= write_q;
				acc.acc_line  <= '{space: shared_q, idx: sel_line};
				acc.wdata     <= wdata_q;
			end
		end
	end

	assign acc_first_o    = first_q || marker;
	assign acc_last_o     = last_q || marker;
	assign tag_o          = marker ? iss.tag : tag_q;
	assign drop_mask_o    = marker ? drop_now : drop_q;
	assign fault_pulse_o  = take && (drop_now != '0);
	assign access_pulse_o = acc.acc_valid;

endmodule

/* rtl/mem_cfg_regs.sv */
`include "gpu_mem_defs.svh"

module mem_cfg_regs (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 cfg_we_i,
	input  logic [1:0]           cfg_addr_i,
	input  logic [15:0]          cfg_wdata_i,
	output logic [15:0]          cfg_rdata_o,
	input  logic                 fault_pulse_i,
	input  logic                 access_pulse_i,
	output logic [`LINE_IDX_W:0] shared_limit_o
);

	localparam int LIMIT_W = `LINE_IDX_W + 1;

	logic [LIMIT_W-1:0] limit_q;
	logic               fault_q;
	logic [15:0]        count_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			limit_q <= LIMIT_W'(`SPACE_LINES);
			fault_q <= 1'b0;
			count_q <= '0;
		end
		else
		begin
			if (cfg_we_i && cfg_addr_i == 2'd0)
			begin
				if (cfg_wdata_i > 16'(`SPACE_LINES))
					limit_q <= LIMIT_W'(`SPACE_LINES);
				else
					limit_q <= cfg_wdata_i[LIMIT_W-1:0];
			end
			// A new fault in the same cycle as a clearing write still sets the flag.
			if (fault_pulse_i)
				fault_q <= 1'b1;
			else if (cfg_we_i && cfg_addr_i == 2'd1)
				fault_q <= 1'b0;
			if (access_pulse_i)
				count_q <= count_q + 16'd1;
		end
	end

	always_comb
	begin
		case (cfg_addr_i)
			2'd0:    cfg_rdata_o = {{(16-LIMIT_W){1'b0}}, limit_q};
			2'd1:    cfg_rdata_o = {15'd0, fault_q};
			2'd2:    cfg_rdata_o = count_q;
			default: cfg_rdata_o = '0;
		endcase
	end

	assign shared_limit_o = limit_q;

endmodule

/* rtl/mem_addr_gen.sv */
`include "gpu_mem_defs.svh"

module mem_addr_gen (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     req_valid_i,
	input  logic                     mem_read_i,
	input  logic                     mem_write_i,
	input  logic                     shared_global_bar_i,
	input  gpu_mem_pkg::warp_tag_t   tag_i,
	input  gpu_mem_pkg::lane_mask_t  pam_i,
	input  gpu_mem_pkg::lane_words_t rs_data_i,
	input  logic [15:0]              offset_i,
	input  gpu_mem_pkg::lane_words_t write_data_i,
	output logic                     busy_o,
	mem_issue_if.src                 iss
);

	gpu_mem_pkg::lane_words_t     eff_addr;
	gpu_mem_pkg::word_t           ofs_ext;
	logic [`WORD_W-`LINE_OFS-1:0] leader;
	logic                         capture;

	assign ofs_ext = {{(`WORD_W-16){offset_i[15]}}, offset_i};

	// A request with neither read nor write set is dropped here.
	assign capture = req_valid_i && !iss.valid && (mem_read_i || mem_write_i);
	assign busy_o = iss.valid;

	always_comb
	begin
		for (int l = 0; l < `NUM_LANES; l++)
			eff_addr[l] = rs_data_i[l] + ofs_ext;
		// The lowest active lane leads the warp.
		leader = eff_addr[0][`WORD_W-1:`LINE_OFS];
		for (int l = `NUM_LANES-1; l >= 0; l--)
		begin
			if (pam_i[l])
				leader = eff_addr[l][`WORD_W-1:`LINE_OFS];
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			iss.valid <= 1'b0;
		else if (capture)
			iss.valid <= 1'b1;
		else if (iss.take)
			iss.valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			iss.is_write    <= mem_write_i;
			iss.is_shared   <= shared_global_bar_i;
			iss.tag         <= tag_i;
			iss.pam         <= pam_i;
			iss.eff_addr    <= eff_addr;
			iss.wdata       <= write_data_i;
			iss.leader_line <= leader;
		end
	end

endmodule

/* rtl/mem_line_if.sv */
`include "gpu_mem_defs.svh"

interface mem_line_if;

	logic                      acc_valid;
	logic                      acc_write;
	gpu_mem_pkg::line_addr_t   acc_line;
	gpu_mem_pkg::lane_mask_t   lane_mask;
	logic [`WORD_SEL_W-1:0]    word_sel [`NUM_LANES];
	gpu_mem_pkg::lane_words_t  wdata;
	gpu_mem_pkg::lane_words_t  rdata;

	// One access per cycle with acc_valid high. Read data follows one cycle later.
	modport ctl (
		output acc_valid, acc_write, acc_line, lane_mask, word_sel, wdata
	);

	modport mem (
		input  acc_valid, acc_write, acc_line, lane_mask, word_sel, wdata,
		output rdata
	);

	modport mon (
		input  rdata
	);

endinterface

/* rtl/mem_issue_if.sv */
`include "gpu_mem_defs.svh"

interface mem_issue_if;

	logic                         valid;
	logic                         is_write;
	logic                         is_shared;
	gpu_mem_pkg::warp_tag_t       tag;
	gpu_mem_pkg::lane_mask_t      pam;
	gpu_mem_pkg::lane_words_t     eff_addr;
	gpu_mem_pkg::lane_words_t     wdata;
	logic [`WORD_W-`LINE_OFS-1:0] leader_line;
	logic                         take;

	// Contents hold while valid is high; take is a single-cycle pulse.
	modport src (
		output valid, is_write, is_shared, tag, pam, eff_addr, wdata, leader_line,
		input  take
	);

	modport dst (
		input  valid, is_write, is_shared, tag, pam, eff_addr, wdata, leader_line,
		output take
	);

endinterface

/* rtl/gpu_mem_pkg.sv */
`include "gpu_mem_defs.svh"

package gpu_mem_pkg;

	typedef logic [`NUM_LANES-1:0] lane_mask_t;

	typedef logic [`WORD_W-1:0] word_t;

	// One word per lane, used for addresses and for data.
	typedef word_t lane_words_t [`NUM_LANES];

	// Tags travel with the warp untouched and come back with done.
	typedef struct packed {
		logic [2:0] warp_id;
		logic [1:0] scb_id;
		logic [4:0] reg_addr;
	} warp_tag_t;

	// Space bit follows shared_global_bar, so 1 selects the shared space.
	typedef struct packed {
		logic                   space;
		logic [`LINE_IDX_W-1:0] idx;
	} line_addr_t;

endpackage

/* rtl/gpu_mem_defs.svh */
`ifndef GPU_MEM_DEFS_SVH
`define GPU_MEM_DEFS_SVH

// Threads per warp.
`define NUM_LANES 8

`define WORD_W 32

// A line is 32 bytes, so eight words.
`define LINE_OFS 5
`define WORD_SEL_W 3

// Each space (global and shared) holds 32 lines.
`define SPACE_LINES 32
`define LINE_IDX_W 5

`endif
